// File: logic/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

   // address split: tag | index | byte offset within the word
   localparam int unsigned TAG_WIDTH    = 44;
   localparam int unsigned INDEX_WIDTH  = 8;
   localparam int unsigned OFFSET_WIDTH = 3;  // 8 bytes per word
   localparam int unsigned ADDR_WIDTH   = TAG_WIDTH + INDEX_WIDTH + OFFSET_WIDTH;

   localparam int unsigned DATA_WIDTH   = 64; // one word per line
   localparam int unsigned NUM_SETS     = 256;

   // geometry of the sram macro the banks are built from
   localparam int unsigned MACRO_WIDTH  = 16;
   localparam int unsigned MACRO_DEPTH  = 256;

   typedef logic [ADDR_WIDTH-1:0]  cache_addr_t;
   typedef logic [TAG_WIDTH-1:0]   cache_tag_t;
   typedef logic [INDEX_WIDTH-1:0] cache_index_t;
   typedef logic [DATA_WIDTH-1:0]  cache_data_t;

   // per-line state, bit 1 valid and bit 0 dirty
   typedef logic [1:0] line_state_t;

   localparam int unsigned STATE_VALID_BIT = 1;
   localparam int unsigned STATE_DIRTY_BIT = 0;

   localparam line_state_t STATE_INVALID = 2'b00; // written by the reset sweep
   localparam line_state_t STATE_CLEAN   = 2'b10; // after a fill
   localparam line_state_t STATE_DIRTY   = 2'b11; // after a write hit

endpackage

`default_nettype wire

// File: logic/cache_msg_pkg.sv
`default_nettype none

package cache_msg_pkg;

   typedef enum logic [1:0] {
      OP_READ  = 2'd0,
      OP_WRITE = 2'd1, // write-back, touches only a hit line
      OP_FILL  = 2'd2  // install a line, returns the victim
   } cache_op_e;

   // lookup controller states
   typedef enum logic [1:0] {
      S_CLEAR   = 2'd0, // post-reset sweep of the state bank
      S_IDLE    = 2'd1,
      S_COMPARE = 2'd2,
      S_RESP    = 2'd3
   } lookup_state_e;

   typedef struct packed {
      cache_op_e                 op;
      cache_geom_pkg::cache_addr_t addr;
      cache_geom_pkg::cache_data_t wdata;
   } cache_req_t;

   // rdata is the hit word on a read hit, otherwise the stored victim word
   typedef struct packed {
      logic                        hit;
      cache_geom_pkg::cache_data_t rdata;
      logic                        victim_valid;
      logic                        victim_dirty;
      cache_geom_pkg::cache_tag_t  victim_tag;
   } cache_resp_t;

endpackage

`default_nettype wire

// File: logic/sram_macro_256x16.sv
`default_nettype none

module sram_macro_256x16 (
   input  logic                         clk,
   input  logic                         ce_n,   // chip enable, active low
   input  logic                         we_n,   // write enable, active low
   input  cache_geom_pkg::cache_index_t addr,
   input  logic [15:0]                  w_mask, // per-bit write mask
   input  logic [15:0]                  wd,
   output logic [15:0]                  rd
);

   logic [cache_geom_pkg::MACRO_WIDTH-1:0] mem [cache_geom_pkg::MACRO_DEPTH];

   // one access per cycle, write or read
   always_ff @(posedge clk) begin
      if (!ce_n) begin
         if (!we_n) begin
            mem[addr] <= (mem[addr] & ~w_mask) | (wd & w_mask);
         end else begin
            rd <= mem[addr]; // read port holds until the next read
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/sp_ram_bank.sv
`default_nettype none

module sp_ram_bank #(
   parameter int unsigned WIDTH = 64
) (
   input  logic                         clk,
   input  logic                         rst_n,  // macros have no reset
   input  logic                         cs,
   input  logic                         we,
   input  cache_geom_pkg::cache_index_t addr,
   input  logic [WIDTH-1:0]             wdata,
   output logic [WIDTH-1:0]             rdata
);

   localparam int unsigned LANE_WIDTH = cache_geom_pkg::MACRO_WIDTH;
   localparam int unsigned NUM_LANES  = (WIDTH + LANE_WIDTH - 1) / LANE_WIDTH;
   localparam int unsigned PAD_WIDTH  = NUM_LANES * LANE_WIDTH;

   logic                  ce_n;
   logic                  we_n;
   logic [LANE_WIDTH-1:0] w_mask;
   logic [PAD_WIDTH-1:0]  wdata_pad;
   logic [PAD_WIDTH-1:0]  rdata_pad;

   assign ce_n   = ~cs; // macro controls are active low
   assign we_n   = ~we;
   assign w_mask = '1;  // whole-word writes only

   // top lane gets zeros above WIDTH, those bits are dropped on read
   assign wdata_pad = PAD_WIDTH'(wdata);
   assign rdata     = rdata_pad[WIDTH-1:0];

   genvar lane;
   generate
      for (lane = 0; lane < NUM_LANES; lane++) begin : g_lane
         sram_macro_256x16 u_macro (
            .clk    (clk),
            .ce_n   (ce_n),
            .we_n   (we_n),
            .addr   (addr),
            .w_mask (w_mask),
            .wd     (wdata_pad[lane*LANE_WIDTH +: LANE_WIDTH]),
            .rd     (rdata_pad[lane*LANE_WIDTH +: LANE_WIDTH])
         );
      end
   endgenerate

endmodule

`default_nettype wire

// File: logic/cache_lookup.sv
`default_nettype none

module cache_lookup (
   input  logic                         clk,
   input  logic                         rst_n,

   input  logic                         req_valid,
   input  cache_msg_pkg::cache_req_t    req,
   output logic                         resp_valid,
   output cache_msg_pkg::cache_resp_t   resp,
   output logic                         ready,

   // shared bank controls
   output logic                         bank_cs,
   output logic                         bank_we,
   output cache_geom_pkg::cache_index_t bank_addr,

   output cache_geom_pkg::cache_tag_t   tag_wdata,
   input  cache_geom_pkg::cache_tag_t   tag_rdata,
   output cache_geom_pkg::cache_data_t  data_wdata,
   input  cache_geom_pkg::cache_data_t  data_rdata,
   output cache_geom_pkg::line_state_t  state_wdata,
   input  cache_geom_pkg::line_state_t  state_rdata
);

   localparam int unsigned OFF_W = cache_geom_pkg::OFFSET_WIDTH;
   localparam int unsigned IDX_W = cache_geom_pkg::INDEX_WIDTH;
   localparam int unsigned TAG_LSB = OFF_W + IDX_W;

   localparam cache_geom_pkg::cache_index_t LAST_SET =
      cache_geom_pkg::cache_index_t'(cache_geom_pkg::NUM_SETS - 1);

   cache_msg_pkg::lookup_state_e state;
   logic                         sweep_on;  // low only in the cycle right after reset
   cache_geom_pkg::cache_index_t clear_idx;

   cache_msg_pkg::cache_req_t    req_q;     // request held for compare and write
   cache_msg_pkg::cache_resp_t   resp_q;

   cache_geom_pkg::cache_tag_t   req_tag;
   cache_geom_pkg::cache_index_t req_idx;
   cache_geom_pkg::cache_index_t req_q_idx;
   logic                         tag_match;
   logic                         line_valid;

   assign req_tag   = req_q.addr[TAG_LSB +: cache_geom_pkg::TAG_WIDTH];
   assign req_idx   = req.addr[OFF_W +: IDX_W];
   assign req_q_idx = req_q.addr[OFF_W +: IDX_W];

   // bank read data is valid in S_COMPARE
   assign line_valid = state_rdata[cache_geom_pkg::STATE_VALID_BIT];
   assign tag_match  = line_valid && (tag_rdata == req_tag);

   assign ready      = (state != cache_msg_pkg::S_CLEAR);
   assign resp_valid = (state == cache_msg_pkg::S_RESP);
   assign resp       = resp_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= cache_msg_pkg::S_CLEAR;
         sweep_on  <= 1'b0;
         clear_idx <= '0;
      end else begin
         unique case (state)
            cache_msg_pkg::S_CLEAR: begin
               sweep_on <= 1'b1;
               if (sweep_on) begin
                  clear_idx <= clear_idx + 1'b1;
                  if (clear_idx == LAST_SET) begin
                     state <= cache_msg_pkg::S_IDLE; // sweep done
                  end
               end
            end
            cache_msg_pkg::S_IDLE: begin
               if (req_valid) begin
                  state <= cache_msg_pkg::S_COMPARE;
               end
            end
            cache_msg_pkg::S_COMPARE: state <= cache_msg_pkg::S_RESP;
            cache_msg_pkg::S_RESP:    state <= cache_msg_pkg::S_IDLE;
            default:                  state <= cache_msg_pkg::S_CLEAR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == cache_msg_pkg::S_IDLE && req_valid) begin
         req_q <= req;
      end
      if (state == cache_msg_pkg::S_COMPARE) begin
         resp_q.hit          <= tag_match && (req_q.op != cache_msg_pkg::OP_FILL);
         resp_q.rdata        <= data_rdata; // hit word or victim word
         resp_q.victim_valid <= line_valid;
         resp_q.victim_dirty <= state_rdata[cache_geom_pkg::STATE_DIRTY_BIT];
         resp_q.victim_tag   <= tag_rdata;
      end
   end

   // bank port: sweep writes, request reads, then hit write or fill
   always_comb begin
      bank_cs     = 1'b0;
      bank_we     = 1'b0;
      bank_addr   = req_q_idx;
      tag_wdata   = req_tag;
      data_wdata  = req_q.wdata;
      state_wdata = cache_geom_pkg::STATE_INVALID;
      unique case (state)
         cache_msg_pkg::S_CLEAR: begin
            bank_cs   = sweep_on;
            bank_we   = 1'b1;
            bank_addr = clear_idx;
         end
         cache_msg_pkg::S_IDLE: begin
            bank_cs   = req_valid; // read all banks in the request cycle
            bank_addr = req_idx;
         end
         cache_msg_pkg::S_COMPARE: begin
            bank_cs = 1'b0;
         end
         cache_msg_pkg::S_RESP: begin
            if (req_q.op == cache_msg_pkg::OP_FILL) begin
               bank_cs     = 1'b1;
               bank_we     = 1'b1;
               state_wdata = cache_geom_pkg::STATE_CLEAN;
            end else if (req_q.op == cache_msg_pkg::OP_WRITE && resp_q.hit) begin
               bank_cs     = 1'b1;
               bank_we     = 1'b1; // tag rewritten unchanged
               state_wdata = cache_geom_pkg::STATE_DIRTY;
            end
         end
         default: begin
            bank_cs = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/cache_store_top.sv
`default_nettype none

module cache_store_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       req_valid,
   input  cache_msg_pkg::cache_req_t  req,
   output logic                       resp_valid,
   output cache_msg_pkg::cache_resp_t resp,
   output logic                       ready
);

   logic                         bank_cs;
   logic                         bank_we;
   cache_geom_pkg::cache_index_t bank_addr;

   cache_geom_pkg::cache_tag_t   tag_wdata;
   cache_geom_pkg::cache_tag_t   tag_rdata;
   cache_geom_pkg::cache_data_t  data_wdata;
   cache_geom_pkg::cache_data_t  data_rdata;
   cache_geom_pkg::line_state_t  state_wdata;
   cache_geom_pkg::line_state_t  state_rdata;

   cache_lookup u_lookup (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req         (req),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .ready       (ready),
      .bank_cs     (bank_cs),
      .bank_we     (bank_we),
      .bank_addr   (bank_addr),
      .tag_wdata   (tag_wdata),
      .tag_rdata   (tag_rdata),
      .data_wdata  (data_wdata),
      .data_rdata  (data_rdata),
      .state_wdata (state_wdata),
      .state_rdata (state_rdata)
   );

   // four macros
   sp_ram_bank #(.WIDTH(cache_geom_pkg::DATA_WIDTH)) data_bank (
      .clk (clk), .rst_n (rst_n), .cs (bank_cs), .we (bank_we), .addr (bank_addr),
      .wdata (data_wdata), .rdata (data_rdata)
   );

   // three macros, top lane only partly used
   sp_ram_bank #(.WIDTH(cache_geom_pkg::TAG_WIDTH)) tag_bank (
      .clk (clk), .rst_n (rst_n), .cs (bank_cs), .we (bank_we), .addr (bank_addr),
      .wdata (tag_wdata), .rdata (tag_rdata)
   );

   // valid/dirty in one macro
   sp_ram_bank #(.WIDTH($bits(cache_geom_pkg::line_state_t))) state_bank (
      .clk (clk), .rst_n (rst_n), .cs (bank_cs), .we (bank_we), .addr (bank_addr),
      .wdata (state_wdata), .rdata (state_rdata)
   );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
   parameter int unsigned PERIOD_NS = 10
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
   end

   always #(PERIOD_NS / 2) clk = ~clk; // even duty cycle

endmodule

`default_nettype wire

// File: testbench/cache_store_checker.sv
`default_nettype none

module cache_store_checker (
   input logic clk,
   input logic rst_n,
   input logic req_valid,
   input logic resp_valid,
   input logic ready
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned violation_count = 0; // read by the testbench

   req_while_clearing: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid |-> ready)
   else begin
      violation_count = violation_count + 1;
      $error("req_valid asserted while ready is low");
   end

   // fixed two-cycle lookup latency, both ways
   resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
      $past(req_valid, 2) == resp_valid)
   else begin
      violation_count = violation_count + 1;
      $error("resp_valid not exactly two cycles after req_valid");
   end

   req_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid |-> !$past(req_valid) && !$past(req_valid, 2))
   else begin
      violation_count = violation_count + 1;
      $error("req_valid asserted while a request is outstanding");
   end

   resp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid |=> !resp_valid)
   else begin
      violation_count = violation_count + 1;
      $error("resp_valid held for more than one cycle");
   end

endmodule

bind cache_store_top cache_store_checker u_checker (
   .clk        (clk),
   .rst_n      (rst_n),
   .req_valid  (req_valid),
   .resp_valid (resp_valid),
   .ready      (ready)
);

`default_nettype wire

// File: testbench/cache_store_tb.sv
`default_nettype none

module cache_store_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned CLK_PERIOD     = 10;
   localparam int unsigned RESET_CYCLES   = 10;
   localparam int unsigned NUM_RANDOM     = 400;
   localparam int unsigned TIMEOUT_CYCLES = cache_geom_pkg::NUM_SETS + 3 * NUM_RANDOM + 200;
   localparam logic [31:0] LFSR_SEED      = 32'h95f8;

   logic                       clk;
   logic                       rst_n;
   logic                       req_valid;
   cache_msg_pkg::cache_req_t  req;
   logic                       resp_valid;
   cache_msg_pkg::cache_resp_t resp;
   logic                       ready;

   // reference copy of every set
   cache_geom_pkg::cache_tag_t  model_tag   [cache_geom_pkg::NUM_SETS];
   logic                        model_valid [cache_geom_pkg::NUM_SETS];
   logic                        model_dirty [cache_geom_pkg::NUM_SETS];
   cache_geom_pkg::cache_data_t model_data  [cache_geom_pkg::NUM_SETS];

   cache_msg_pkg::cache_resp_t expected_q [$];
   int unsigned                resp_count = 0;
   int unsigned                cycle_count = 0;
   logic [31:0]                lfsr_state;

   tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

   cache_store_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .resp_valid (resp_valid),
      .resp       (resp),
      .ready      (ready)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [63:0] take_bits(input int unsigned n);
      logic [63:0] value;
      value = '0;
      for (int unsigned i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state); // one step per bit
         value      = {value[62:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // few tags, so random traffic hits as well as conflicts
   function automatic cache_geom_pkg::cache_tag_t pool_tag(input logic [1:0] sel);
      case (sel)
         2'd0:    return 44'hF0F_0F0F_0F0F;
         2'd1:    return 44'h123_4567_89AB;
         2'd2:    return 44'hA5A_5A5A_5A5A;
         default: return 44'h0DE_ADBE_EF01;
      endcase
   endfunction

   function automatic cache_geom_pkg::cache_addr_t make_addr(
      input cache_geom_pkg::cache_tag_t tag, input cache_geom_pkg::cache_index_t idx);
      return {tag, idx, 3'b000};
   endfunction

   // expected response, then the line update the request causes
   function automatic cache_msg_pkg::cache_resp_t model_access(
      input cache_msg_pkg::cache_req_t r);
      cache_msg_pkg::cache_resp_t   exp;
      cache_geom_pkg::cache_tag_t   tag;
      cache_geom_pkg::cache_index_t idx;
      logic                         match;
      tag   = r.addr[cache_geom_pkg::ADDR_WIDTH-1 -: cache_geom_pkg::TAG_WIDTH];
      idx   = r.addr[cache_geom_pkg::OFFSET_WIDTH +: cache_geom_pkg::INDEX_WIDTH];
      match = model_valid[idx] && (model_tag[idx] == tag);
      exp.hit          = match && (r.op != cache_msg_pkg::OP_FILL);
      exp.rdata        = model_data[idx]; // line contents before any write
      exp.victim_valid = model_valid[idx];
      exp.victim_dirty = model_dirty[idx];
      exp.victim_tag   = model_tag[idx];
      if (r.op == cache_msg_pkg::OP_WRITE && match) begin
         model_data[idx]  = r.wdata;
         model_dirty[idx] = 1'b1;
      end else if (r.op == cache_msg_pkg::OP_FILL) begin
         model_tag[idx]   = tag;
         model_data[idx]  = r.wdata;
         model_valid[idx] = 1'b1;
         model_dirty[idx] = 1'b0;
      end
      return exp;
   endfunction

   task end_with_failure(input string reason);
      $display("%s", reason);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         end_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task next_cycle();
      @(posedge clk);
      #1; // drive and look just after the edge
   endtask

   // one request, then wait for its response to be checked
   task automatic issue(input cache_msg_pkg::cache_op_e op,
      input cache_geom_pkg::cache_addr_t addr, input cache_geom_pkg::cache_data_t wdata);
      cache_msg_pkg::cache_req_t r;
      int unsigned               target;
      r.op     = op;
      r.addr   = addr;
      r.wdata  = wdata;
      target   = resp_count + 1;
      expected_q.push_back(model_access(r));
      req       = r;
      req_valid = 1'b1;
      next_cycle();
      req_valid = 1'b0;
      while (resp_count < target) begin
         next_cycle();
      end
   endtask

   always @(negedge clk) begin : compare_resp
      cache_msg_pkg::cache_resp_t exp;
      if (rst_n && resp_valid) begin
         if (expected_q.size() == 0) begin
            end_with_failure("response arrived with no request outstanding");
         end else begin
            exp = expected_q.pop_front();
            check_value("resp.hit", 64'(resp.hit), 64'(exp.hit));
            check_value("resp.victim_valid", 64'(resp.victim_valid), 64'(exp.victim_valid));
            check_value("resp.victim_dirty", 64'(resp.victim_dirty), 64'(exp.victim_dirty));
            if (exp.victim_valid) begin // tag and data banks are unset before a fill
               check_value("resp.victim_tag", 64'(resp.victim_tag), 64'(exp.victim_tag));
               check_value("resp.rdata", resp.rdata, exp.rdata);
            end
            resp_count++;
         end
      end
   end

   always @(negedge clk) begin : watchdog
      cycle_count++;
      if (DUT.u_checker.violation_count != 0) begin
         end_with_failure("a protocol assertion on the DUT failed");
      end else if (cycle_count > TIMEOUT_CYCLES) begin
         end_with_failure($sformatf("timeout, no end of test after %0d cycles", cycle_count));
      end
   end

   initial begin : stimulus
      cache_msg_pkg::cache_op_e     op;
      cache_geom_pkg::cache_index_t idx;
      cache_geom_pkg::cache_tag_t   tag;
      cache_geom_pkg::cache_data_t  wdata;
      logic [1:0]                   op_bits;
      int unsigned                  wait_cycles;
      int unsigned                  set_i;
      rst_n      = 1'b0;
      req_valid  = 1'b0;
      req        = '0;
      lfsr_state = LFSR_SEED;
      for (set_i = 0; set_i < cache_geom_pkg::NUM_SETS; set_i++) begin
         model_tag[set_i]   = '0;
         model_valid[set_i] = 1'b0;
         model_dirty[set_i] = 1'b0;
         model_data[set_i]  = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
      check_value("ready", 64'(ready), 64'(0));
      wait_cycles = 0;
      while (!ready) begin
         next_cycle();
         wait_cycles++;
      end
      // counted from one cycle before the first edge that sees rst_n high
      check_value("ready_delay", 64'(wait_cycles), 64'(cache_geom_pkg::NUM_SETS + 1));

      // first touches of a set all miss
      issue(cache_msg_pkg::OP_READ, make_addr(pool_tag(2'd0), 8'h00), '0);
      issue(cache_msg_pkg::OP_READ, make_addr(pool_tag(2'd1), 8'h01), '0);
      issue(cache_msg_pkg::OP_READ, make_addr(pool_tag(2'd2), 8'h80), '0);
      issue(cache_msg_pkg::OP_READ, make_addr(pool_tag(2'd3), 8'hff), '0);

      // fill then read back
      issue(cache_msg_pkg::OP_FILL, make_addr(pool_tag(2'd0), 8'h05), take_bits(64));
      issue(cache_msg_pkg::OP_READ, make_addr(pool_tag(2'd0), 8'h05), '0);

      // write hit makes the line dirty, conflicting fill evicts it
      issue(cache_msg_pkg::OP_WRITE, make_addr(pool_tag(2'd0), 8'h05), take_bits(64));
      issue(cache_msg_pkg::OP_FILL, make_addr(pool_tag(2'd1), 8'h05), take_bits(64));

      // write miss leaves the line alone
      issue(cache_msg_pkg::OP_WRITE, make_addr(pool_tag(2'd2), 8'h05), take_bits(64));
      issue(cache_msg_pkg::OP_READ, make_addr(pool_tag(2'd2), 8'h05), '0);

      repeat (NUM_RANDOM) begin
         op_bits = 2'(take_bits(2));
         op      = (op_bits == 2'd3) ? cache_msg_pkg::OP_READ
                                     : cache_msg_pkg::cache_op_e'(op_bits);
         idx     = cache_geom_pkg::cache_index_t'(take_bits(3)); // sets 0 to 7
         tag     = pool_tag(2'(take_bits(2)));
         wdata   = take_bits(64);
         issue(op, make_addr(tag, idx), wdata);
      end

      if (expected_q.size() == 0 && DUT.u_checker.violation_count == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         end_with_failure("responses missing or protocol assertions failed at end of run");
      end
   end

endmodule

`default_nettype wire

// File: cache_store.f
logic/cache_geom_pkg.sv
logic/cache_msg_pkg.sv
logic/sram_macro_256x16.sv
logic/sp_ram_bank.sv
logic/cache_lookup.sv
logic/cache_store_top.sv
testbench/tb_clock_gen.sv
testbench/cache_store_checker.sv
testbench/cache_store_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cache store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
   --top-module cache_store_tb -f cache_store.f -o sim_cache_store
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

# let assertion errors reach the testbench instead of ending the run
sim_output=$(./obj_dir/sim_cache_store +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "RESULT: PASS" <<< "$sim_output"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi
